// File: cpu_pkg.sv
package cpu_pkg;

    // Datapath widths.
    parameter int WORD_W    = 16;
    parameter int BYTE_W    = 8;
    parameter int PADDR_W   = 20;
    parameter int REG_IDX_W = 3;

    // Operation kinds carried from the decoder to the execute stage.
    typedef enum logic [2:0] {
        mov_imm,
        mov_reg_reg,
        mov_mem_to_reg,
        mov_reg_to_mem,
        push_reg,
        pop_reg,
        halt,
        nop
    } op_kind_e;

    typedef struct packed {
        logic [1:0] mod;
        logic [2:0] rm;
    } mod_rm_t;

    // Direct addressing (A1/A3 and mod 00 rm 110) arrives as mod 00, rm 110,
    // with the address in disp.
    typedef struct packed {
        op_kind_e               kind;
        logic                   is_word;
        logic [REG_IDX_W-1:0]   dst;
        logic [REG_IDX_W-1:0]   src;
        mod_rm_t                mod_rm;
        logic [WORD_W-1:0]      disp;
        logic [WORD_W-1:0]      imm;
    } uop_t;

    // One request port for the data RAM. The address is a byte address.
    typedef struct packed {
        logic                   en;
        logic                   we;
        logic [PADDR_W-1:0]     addr;
        logic [WORD_W-1:0]      wdata;
    } mem_req_t;

endpackage

// File: inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder #(
    parameter logic [cpu_pkg::PADDR_W-1:0] CODE_BASE = '0
) (
    input  logic                         clk,
    input  logic                         rst,
    output logic [cpu_pkg::PADDR_W-1:0]  rom_addr,
    input  logic [cpu_pkg::BYTE_W-1:0]   rom_data,
    output logic                         push_req,
    output cpu_pkg::uop_t                push_uop,
    input  logic                         push_ack
);

    import cpu_pkg::*;

    typedef enum logic [2:0] {
        S_OP,
        S_MODRM,
        S_DATA,
        S_REQ,
        S_ACK_LOW,
        S_HALT
    } dec_state_e;

    dec_state_e         state;
    logic [WORD_W-1:0]  fetch_off;
    logic [1:0]         left;
    logic               idx;
    logic [BYTE_W-1:0]  opcode;
    logic [BYTE_W-1:0]  modrm;
    logic [WORD_W-1:0]  data;

    // Immediate or address bytes that follow the opcode directly.
    function automatic logic [1:0] op_bytes(input logic [BYTE_W-1:0] op);
        logic [1:0] n;
        casez (op)
            8'b1011_0???:   n = 2'd1;
            8'b1011_1???:   n = 2'd2;
            8'hA1, 8'hA3:   n = 2'd2;
            default:        n = 2'd0;
        endcase
        return n;
    endfunction

    function automatic logic has_modrm(input logic [BYTE_W-1:0] op);
        return op[7:2] == 6'b100010;
    endfunction

    // Displacement length after a modrm byte.
    function automatic logic [1:0] disp_bytes(input logic [BYTE_W-1:0] m);
        logic [1:0] n;
        case (m[7:6])
            2'b00:   n = (m[2:0] == 3'b110) ? 2'd2 : 2'd0;
            2'b01:   n = 2'd1;
            2'b10:   n = 2'd2;
            default: n = 2'd0;
        endcase
        return n;
    endfunction

    // The code base is a paragraph number, like a segment value.
    assign rom_addr = PADDR_W'(CODE_BASE << 4) + PADDR_W'(fetch_off);
    assign push_req = (state == S_REQ);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= S_OP;
            fetch_off <= '0;
            left      <= '0;
            idx       <= 1'b0;
        end else begin
            case (state)
                S_OP: begin
                    fetch_off <= fetch_off + 1'b1;
                    idx       <= 1'b0;
                    left      <= op_bytes(rom_data);
                    if (has_modrm(rom_data)) begin
                        state <= S_MODRM;
                    end else if (op_bytes(rom_data) != 2'd0) begin
                        state <= S_DATA;
                    end else begin
                        state <= S_REQ;
                    end
                end
                S_MODRM: begin
                    fetch_off <= fetch_off + 1'b1;
                    left      <= disp_bytes(rom_data);
                    state     <= (disp_bytes(rom_data) != 2'd0) ? S_DATA : S_REQ;
                end
                S_DATA: begin
                    fetch_off <= fetch_off + 1'b1;
                    idx       <= 1'b1;
                    left      <= left - 1'b1;
                    if (left == 2'd1) begin
                        state <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (push_ack) begin
                        state <= S_ACK_LOW;
                    end
                end
                S_ACK_LOW: begin
                    if (!push_ack) begin
                        state <= (opcode == 8'hF4) ? S_HALT : S_OP;
                    end
                end
                default: begin
                    state <= S_HALT;
                end
            endcase
        end
    end

    // Instruction bytes are gathered little-endian into data.
    always_ff @(posedge clk) begin
        if (state == S_OP) begin
            opcode <= rom_data;
            modrm  <= '0;
            data   <= '0;
        end
        if (state == S_MODRM) begin
            modrm <= rom_data;
        end
        if (state == S_DATA) begin
            if (idx) begin
                data[WORD_W-1:BYTE_W] <= rom_data;
            end else begin
                data[BYTE_W-1:0] <= rom_data;
            end
        end
    end

    always_comb begin
        push_uop         = '0;
        push_uop.kind    = nop;
        push_uop.is_word = 1'b1;
        casez (opcode)
            8'b1011_????: begin
                push_uop.kind    = mov_imm;
                push_uop.is_word = opcode[3];
                push_uop.dst     = opcode[2:0];
                push_uop.imm     = data;
            end
            8'hA1, 8'hA3: begin
                push_uop.kind       = opcode[1] ? mov_reg_to_mem : mov_mem_to_reg;
                push_uop.mod_rm.mod = 2'b00;
                push_uop.mod_rm.rm  = 3'b110;
                push_uop.disp       = data;
            end
            8'b1000_10??: begin
                push_uop.is_word    = opcode[0];
                push_uop.mod_rm.mod = modrm[7:6];
                push_uop.mod_rm.rm  = modrm[2:0];
                push_uop.disp       = (modrm[7:6] == 2'b01) ?
                                      {{BYTE_W{data[7]}}, data[BYTE_W-1:0]} : data;
                push_uop.dst        = opcode[1] ? modrm[5:3] : modrm[2:0];
                push_uop.src        = opcode[1] ? modrm[2:0] : modrm[5:3];
                // Byte forms with a memory operand stay no-ops.
                if (modrm[7:6] == 2'b11) begin
                    push_uop.kind = mov_reg_reg;
                end else if (opcode[0]) begin
                    push_uop.kind = opcode[1] ? mov_mem_to_reg : mov_reg_to_mem;
                end
            end
            8'b0101_0???: begin
                push_uop.kind = push_reg;
                push_uop.src  = opcode[2:0];
            end
            8'b0101_1???: begin
                push_uop.kind = pop_reg;
                push_uop.dst  = opcode[2:0];
            end
            8'hF4: begin
                push_uop.kind = halt;
            end
            default: begin
                push_uop.kind = nop;
            end
        endcase
    end

endmodule

// File: uop_queue.sv
`timescale 1ns/100ps

module uop_queue #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic push_req,
    input  T     push_data,
    output logic push_ack,
    output logic pop_req,
    output T     pop_data,
    input  logic pop_ack
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T               mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic           do_push;
    logic           do_pop;

    // A full queue holds ack low, which stalls the producer.
    assign do_push  = push_req && !push_ack && (count != CNT_W'(DEPTH));
    assign do_pop   = pop_req && pop_ack;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            push_ack <= 1'b0;
            pop_req  <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
        end else begin
            if (do_push) begin
                push_ack <= 1'b1;
                wr_ptr   <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end else if (!push_req) begin
                push_ack <= 1'b0;
            end

            // The head leaves as soon as the consumer acknowledges it.
            if (do_pop) begin
                pop_req <= 1'b0;
                rd_ptr  <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end else if (!pop_ack && count != '0) begin
                pop_req <= 1'b1;
            end

            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// File: gp_regfile.sv
`timescale 1ns/100ps

module gp_regfile #(
    parameter logic [cpu_pkg::WORD_W-1:0] SP_INIT = 16'h0100
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [cpu_pkg::REG_IDX_W-1:0] rd_idx,
    input  logic                          rd_word,
    output logic [cpu_pkg::WORD_W-1:0]    rd_data,
    input  logic                          wr_en,
    input  logic [cpu_pkg::REG_IDX_W-1:0] wr_idx,
    input  logic                          wr_word,
    input  logic [cpu_pkg::WORD_W-1:0]    wr_data,
    input  logic                          sp_dec,
    input  logic                          sp_inc,
    output logic [cpu_pkg::WORD_W-1:0]    sp,
    output logic [cpu_pkg::WORD_W-1:0]    bx,
    output logic [cpu_pkg::WORD_W-1:0]    bp,
    output logic [cpu_pkg::WORD_W-1:0]    si,
    output logic [cpu_pkg::WORD_W-1:0]    di
);

    import cpu_pkg::*;

    localparam int SP_IDX = 4;

    // AX, CX, DX, BX, SP, BP, SI, DI in encoding order.
    logic [WORD_W-1:0] regs [8];

    // Byte indices 0-3 are AL..BL and 4-7 are AH..BH.
    always_comb begin
        if (rd_word) begin
            rd_data = regs[rd_idx];
        end else if (rd_idx[2]) begin
            rd_data = {{(WORD_W-BYTE_W){1'b0}}, regs[rd_idx[1:0]][WORD_W-1:BYTE_W]};
        end else begin
            rd_data = {{(WORD_W-BYTE_W){1'b0}}, regs[rd_idx[1:0]][BYTE_W-1:0]};
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= (i == SP_IDX) ? SP_INIT : '0;
            end
        end else begin
            if (sp_dec) begin
                regs[SP_IDX] <= regs[SP_IDX] - WORD_W'(2);
            end else if (sp_inc) begin
                regs[SP_IDX] <= regs[SP_IDX] + WORD_W'(2);
            end
            // A write lands after the stack step, so POP SP keeps the loaded word.
            if (wr_en) begin
                if (wr_word) begin
                    regs[wr_idx] <= wr_data;
                end else if (wr_idx[2]) begin
                    regs[wr_idx[1:0]][WORD_W-1:BYTE_W] <= wr_data[BYTE_W-1:0];
                end else begin
                    regs[wr_idx[1:0]][BYTE_W-1:0] <= wr_data[BYTE_W-1:0];
                end
            end
        end
    end

    assign sp = regs[SP_IDX];
    assign bx = regs[3];
    assign bp = regs[5];
    assign si = regs[6];
    assign di = regs[7];

endmodule

// File: exec_unit.sv
`timescale 1ns/100ps

module exec_unit #(
    parameter logic [cpu_pkg::PADDR_W-1:0] DATA_BASE  = '0,
    parameter logic [cpu_pkg::PADDR_W-1:0] STACK_BASE = '0,
    parameter logic [cpu_pkg::WORD_W-1:0]  SP_INIT    = 16'h0100
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pop_req,
    input  cpu_pkg::uop_t              pop_uop,
    output logic                       pop_ack,
    output cpu_pkg::mem_req_t          mem_req,
    input  logic [cpu_pkg::WORD_W-1:0] mem_rdata,
    output logic                       halted
);

    import cpu_pkg::*;

    typedef enum logic [1:0] {
        E_IDLE,
        E_EXEC,
        E_LOAD,
        E_HALT
    } exec_state_e;

    exec_state_e        state;
    uop_t               cur;
    logic [WORD_W-1:0]  rd_data;
    logic [WORD_W-1:0]  sp;
    logic [WORD_W-1:0]  bx;
    logic [WORD_W-1:0]  bp;
    logic [WORD_W-1:0]  si;
    logic [WORD_W-1:0]  di;
    logic [WORD_W-1:0]  ea_base;
    logic [WORD_W-1:0]  ea;
    logic               is_load;
    logic               is_store;
    logic               wr_en;
    logic [WORD_W-1:0]  wr_data;
    logic               sp_dec;
    logic               sp_inc;
    logic               take;

    assign take     = (state == E_IDLE) && pop_req && !pop_ack;
    assign is_load  = (cur.kind == mov_mem_to_reg) || (cur.kind == pop_reg);
    assign is_store = (cur.kind == mov_reg_to_mem) || (cur.kind == push_reg);

    always_comb begin
        case (cur.mod_rm.rm)
            3'b000:  ea_base = bx + si;
            3'b001:  ea_base = bx + di;
            3'b010:  ea_base = bp + si;
            3'b011:  ea_base = bp + di;
            3'b100:  ea_base = si;
            3'b101:  ea_base = di;
            3'b110:  ea_base = bp;
            default: ea_base = bx;
        endcase
        if (cur.mod_rm.mod == 2'b00 && cur.mod_rm.rm == 3'b110) begin
            ea = cur.disp;
        end else begin
            ea = ea_base + cur.disp;
        end
    end

    // One access per operation, issued in the cycle after the uop is taken.
    always_comb begin
        mem_req.en    = (state == E_EXEC) && (is_load || is_store);
        mem_req.we    = is_store;
        mem_req.wdata = rd_data;
        case (cur.kind)
            push_reg: mem_req.addr = STACK_BASE + PADDR_W'(sp - WORD_W'(2));
            pop_reg:  mem_req.addr = STACK_BASE + PADDR_W'(sp);
            default:  mem_req.addr = DATA_BASE + PADDR_W'(ea);
        endcase
    end

    assign sp_dec  = (state == E_EXEC) && (cur.kind == push_reg);
    assign sp_inc  = (state == E_EXEC) && (cur.kind == pop_reg);
    assign wr_en   = ((state == E_EXEC) && (cur.kind == mov_imm || cur.kind == mov_reg_reg))
                     || (state == E_LOAD);
    assign wr_data = (state == E_LOAD) ? mem_rdata :
                     (cur.kind == mov_imm) ? cur.imm : rd_data;

    gp_regfile #(
        .SP_INIT (SP_INIT)
    ) u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rd_idx  (cur.src),
        .rd_word (cur.is_word),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_idx  (cur.dst),
        .wr_word (cur.is_word),
        .wr_data (wr_data),
        .sp_dec  (sp_dec),
        .sp_inc  (sp_inc),
        .sp      (sp),
        .bx      (bx),
        .bp      (bp),
        .si      (si),
        .di      (di)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= E_IDLE;
            pop_ack <= 1'b0;
            halted  <= 1'b0;
        end else begin
            case (state)
                E_IDLE: begin
                    if (pop_ack && !pop_req) begin
                        pop_ack <= 1'b0;
                    end else if (take) begin
                        pop_ack <= 1'b1;
                        state   <= E_EXEC;
                    end
                end
                E_EXEC: begin
                    if (cur.kind == halt) begin
                        halted <= 1'b1;
                        state  <= E_HALT;
                    end else if (is_load) begin
                        state <= E_LOAD;
                    end else begin
                        state <= E_IDLE;
                    end
                end
                E_LOAD: begin
                    state <= E_IDLE;
                end
                default: begin
                    // Finish the last handshake and take nothing more.
                    if (pop_ack && !pop_req) begin
                        pop_ack <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cur <= pop_uop;
        end
    end

endmodule

// File: core_top.sv
`timescale 1ns/100ps

module core_top #(
    parameter logic [cpu_pkg::PADDR_W-1:0] CODE_BASE   = '0,
    parameter logic [cpu_pkg::PADDR_W-1:0] DATA_BASE   = 20'h01000,
    parameter logic [cpu_pkg::PADDR_W-1:0] STACK_BASE  = 20'h02000,
    parameter logic [cpu_pkg::WORD_W-1:0]  SP_INIT     = 16'h0100,
    parameter int                          QUEUE_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    output logic [cpu_pkg::PADDR_W-1:0] rom_addr,
    input  logic [cpu_pkg::BYTE_W-1:0]  rom_data,
    output cpu_pkg::mem_req_t           mem_req,
    input  logic [cpu_pkg::WORD_W-1:0]  mem_rdata,
    output logic                        halted
);

    import cpu_pkg::*;

    logic push_req;
    logic push_ack;
    uop_t push_uop;
    logic pop_req;
    logic pop_ack;
    uop_t pop_uop;

    inst_decoder #(
        .CODE_BASE (CODE_BASE)
    ) u_decoder (
        .clk      (clk),
        .rst      (rst),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .push_req (push_req),
        .push_uop (push_uop),
        .push_ack (push_ack)
    );

    uop_queue #(
        .T     (uop_t),
        .DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk       (clk),
        .rst       (rst),
        .push_req  (push_req),
        .push_data (push_uop),
        .push_ack  (push_ack),
        .pop_req   (pop_req),
        .pop_data  (pop_uop),
        .pop_ack   (pop_ack)
    );

    exec_unit #(
        .DATA_BASE  (DATA_BASE),
        .STACK_BASE (STACK_BASE),
        .SP_INIT    (SP_INIT)
    ) u_exec (
        .clk       (clk),
        .rst       (rst),
        .pop_req   (pop_req),
        .pop_uop   (pop_uop),
        .pop_ack   (pop_ack),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

endmodule

// File: core_asserts.sv
`timescale 1ns/100ps

module core_asserts (
    input logic clk,
    input logic rst,
    input logic push_req,
    input logic push_ack,
    input logic pop_req,
    input logic pop_ack,
    input logic mem_en,
    input logic halted
);

    int unsigned fails = 0;

    // A request stays up until its acknowledge arrives.
    push_hold: assert property (@(posedge clk) disable iff (!rst)
        push_req && !push_ack |=> push_req)
        else begin
            $error("push_req fell before push_ack");
            fails++;
        end

    // A new request waits for the previous acknowledge to fall.
    push_rise: assert property (@(posedge clk) disable iff (!rst)
        $rose(push_req) |-> !push_ack)
        else begin
            $error("push_req rose while push_ack was high");
            fails++;
        end

    pop_hold: assert property (@(posedge clk) disable iff (!rst)
        pop_req && !pop_ack |=> pop_req)
        else begin
            $error("pop_req fell before pop_ack");
            fails++;
        end

    pop_rise: assert property (@(posedge clk) disable iff (!rst)
        $rose(pop_req) |-> !pop_ack)
        else begin
            $error("pop_req rose while pop_ack was high");
            fails++;
        end

    // A halted core makes no more memory accesses.
    halt_quiet: assert property (@(posedge clk) disable iff (!rst)
        halted |-> !mem_en)
        else begin
            $error("memory request while halted");
            fails++;
        end

endmodule

bind core_top core_asserts u_asserts (
    .clk      (clk),
    .rst      (rst),
    .push_req (push_req),
    .push_ack (push_ack),
    .pop_req  (pop_req),
    .pop_ack  (pop_ack),
    .mem_en   (mem_req.en),
    .halted   (halted)
);

// File: tb_core.sv
`timescale 1ns/100ps

module tb_core;

    import cpu_pkg::*;

    localparam logic [PADDR_W-1:0] CODE_BASE  = 20'h00000;
    localparam logic [PADDR_W-1:0] DATA_BASE  = 20'h01000;
    localparam logic [PADDR_W-1:0] STACK_BASE = 20'h02000;
    localparam logic [WORD_W-1:0]  SP_INIT    = 16'h0100;
    localparam int                 QUEUE_DEPTH = 4;

    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 4;
    localparam int SETTLE_CYCLES  = 8;
    localparam int CYCLES_PER_ROW = 200;
    localparam int NUM_ROWS       = 7;
    localparam int MAX_PROG       = 24;
    localparam int MAX_WR         = 4;
    localparam int ROM_AW         = 5;
    localparam int RAM_WORDS      = 1 << (PADDR_W - 1);

    typedef logic [8*MAX_PROG-1:0] prog_t;

    typedef struct packed {
        logic [PADDR_W-1:0] addr;
        logic [WORD_W-1:0]  data;
    } wr_t;

    logic               clk;
    logic               rst;
    logic [PADDR_W-1:0] rom_addr;
    logic [BYTE_W-1:0]  rom_data;
    mem_req_t           mem_req;
    logic [WORD_W-1:0]  mem_rdata;
    logic               halted;

    logic [BYTE_W-1:0]  rom [1 << ROM_AW];
    logic [WORD_W-1:0]  ram [RAM_WORDS];
    logic [WORD_W-1:0]  rd_hold;
    wr_t                seen_q [$];

    // Test table of program bytes and the RAM writes they must produce.
    string              row_name [NUM_ROWS];
    logic [BYTE_W-1:0]  row_prog [NUM_ROWS][MAX_PROG];
    int                 row_nwr  [NUM_ROWS];
    wr_t                row_wr   [NUM_ROWS][MAX_WR];
    int                 n_rows;

    core_top #(
        .CODE_BASE   (CODE_BASE),
        .DATA_BASE   (DATA_BASE),
        .STACK_BASE  (STACK_BASE),
        .SP_INIT     (SP_INIT),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Fetches beyond the modeled ROM read HLT.
    assign rom_data = (rom_addr < PADDR_W'(1 << ROM_AW)) ? rom[rom_addr[ROM_AW-1:0]] : 8'hF4;

    // Writes land at the edge of the request; read data follows one cycle later.
    always @(posedge clk) begin
        if (mem_req.en === 1'b1) begin
            if (mem_req.we) begin
                seen_q.push_back({mem_req.addr, mem_req.wdata});
                ram[mem_req.addr[PADDR_W-1:1]] = mem_req.wdata;
            end else begin
                rd_hold = ram[mem_req.addr[PADDR_W-1:1]];
                #1;
                mem_rdata = rd_hold;
            end
        end
    end

    function automatic logic [WORD_W-1:0] fill_word(input logic [PADDR_W-1:0] a);
        return a[15:0] ^ 16'hA5A5;
    endfunction

    task automatic add_row(input string name, input int len, input prog_t bytes);
        row_name[n_rows] = name;
        row_nwr[n_rows]  = 0;
        for (int i = 0; i < MAX_PROG; i++) begin
            if (i < len) begin
                row_prog[n_rows][i] = bytes[8*(len-1-i) +: 8];
            end else begin
                row_prog[n_rows][i] = 8'hF4;
            end
        end
        n_rows++;
    endtask

    task automatic add_write(input logic [PADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
        int r;
        r = n_rows - 1;
        row_wr[r][row_nwr[r]].addr = addr;
        row_wr[r][row_nwr[r]].data = data;
        row_nwr[r]++;
    endtask

    task automatic build_table();
        add_row("imm_direct_store", 7, prog_t'({8'hB8, 8'h34, 8'h12, 8'hA3, 8'h10, 8'h00,
                8'hF4}));
        add_write(DATA_BASE + 20'h0010, 16'h1234);

        add_row("byte_halves", 8, prog_t'({8'hB0, 8'h5A, 8'hB4, 8'hC3, 8'hA3, 8'h20, 8'h00,
                8'hF4}));
        add_write(DATA_BASE + 20'h0020, 16'hC35A);

        // AX to CX, CX to DX, DL to BH, then store DX, BX and CX.
        add_row("reg_moves", 22, prog_t'({8'hB8, 8'hCD, 8'hAB, 8'h89, 8'hC1, 8'h8B, 8'hD1,
                8'h88, 8'hD7, 8'h89, 8'h16, 8'h30, 8'h00, 8'h89, 8'h1E, 8'h32, 8'h00,
                8'h89, 8'h0E, 8'h34, 8'h00, 8'hF4}));
        add_write(DATA_BASE + 20'h0030, 16'hABCD);
        add_write(DATA_BASE + 20'h0032, 16'hCD00);
        add_write(DATA_BASE + 20'h0034, 16'hABCD);

        // BX+SI is 0248 and the disp8 of F8 takes it back to 0240.
        add_row("load_direct_indexed", 19, prog_t'({8'hBB, 8'h00, 8'h02, 8'hBE, 8'h48, 8'h00,
                8'hA1, 8'h00, 8'h01, 8'hA3, 8'h50, 8'h00, 8'h8B, 8'h40, 8'hF8,
                8'hA3, 8'h52, 8'h00, 8'hF4}));
        add_write(DATA_BASE + 20'h0050, fill_word(DATA_BASE + 20'h0100));
        add_write(DATA_BASE + 20'h0052, fill_word(DATA_BASE + 20'h0240));

        add_row("load_bp_disp16", 11, prog_t'({8'hBD, 8'h10, 8'h00, 8'h8B, 8'h86, 8'h00,
                8'h03, 8'hA3, 8'h54, 8'h00, 8'hF4}));
        add_write(DATA_BASE + 20'h0054, fill_word(DATA_BASE + 20'h0310));

        add_row("stack", 15, prog_t'({8'hB9, 8'h11, 8'h11, 8'hBA, 8'h22, 8'h22, 8'h51,
                8'h52, 8'h5B, 8'h89, 8'h1E, 8'h40, 8'h00, 8'h51, 8'hF4}));
        add_write(STACK_BASE + PADDR_W'(SP_INIT) - 20'd2, 16'h1111);
        add_write(STACK_BASE + PADDR_W'(SP_INIT) - 20'd4, 16'h2222);
        add_write(DATA_BASE + 20'h0040, 16'h2222);
        add_write(STACK_BASE + PADDR_W'(SP_INIT) - 20'd4, 16'h1111);

        // 90 is unknown and 88 with a memory operand is dropped, so both do nothing.
        add_row("halt_and_nop", 19, prog_t'({8'hB8, 8'h77, 8'h66, 8'h90, 8'h88, 8'h06,
                8'h70, 8'h00, 8'hA3, 8'h60, 8'h00, 8'hF4, 8'hA3, 8'h62, 8'h00,
                8'h89, 8'h1E, 8'h64, 8'h00}));
        add_write(DATA_BASE + 20'h0060, 16'h6677);
    endtask

    task automatic check_value(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s %s: expected %0h, actual %0h", test_name, what,
                     expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic apply_row(input int r);
        @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < (1 << ROM_AW); i++) begin
            if (i < MAX_PROG) begin
                rom[i] = row_prog[r][i];
            end else begin
                rom[i] = 8'hF4;
            end
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = fill_word(PADDR_W'(i) << 1);
        end
        seen_q.delete();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;
        while (halted !== 1'b1) @(posedge clk);
        // A few more cycles so that any stray write after HLT is seen.
        repeat (SETTLE_CYCLES) @(posedge clk);
        check_value(row_name[r], "write count", 32'(row_nwr[r]), 32'(seen_q.size()));
        for (int k = 0; k < row_nwr[r]; k++) begin
            check_value(row_name[r], $sformatf("write %0d address", k),
                        32'(row_wr[r][k].addr), 32'(seen_q[k].addr));
            check_value(row_name[r], $sformatf("write %0d data", k),
                        32'(row_wr[r][k].data), 32'(seen_q[k].data));
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b0;
        mem_rdata = '0;
        n_rows    = 0;
        for (int i = 0; i < (1 << ROM_AW); i++) begin
            rom[i] = 8'hF4;
        end
        build_table();
        for (int r = 0; r < n_rows; r++) begin
            apply_row(r);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    // The first failed handshake or memory port assertion ends the run.
    initial begin
        wait (DUT.u_asserts.fails != 0);
        $display("assertion failure: a handshake or memory port rule was broken");
        $display("TESTBENCH FAILED");
        $fatal(1, "concurrent assertion failed");
    end

    initial begin
        #(NUM_ROWS * CYCLES_PER_ROW * CLK_PERIOD);
        $display("timeout: the core did not finish all programs within %0d cycles",
                 NUM_ROWS * CYCLES_PER_ROW);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: flist.f
cpu_pkg.sv
inst_decoder.sv
uop_queue.sv
gp_regfile.sv
exec_unit.sv
core_top.sv
core_asserts.sv
tb_core.sv
